// File: rtl/hps_pkg.sv
package hps_pkg;

	//////////////////////////////////////////////////
	// host bus geometry

	localparam int DATA_W = 16;
	// word index inside a frame, stops at 15
	localparam int IDX_W  = 4;
	localparam int ADDR_W = 27;

	//////////////////////////////////////////////////
	// command codes

	// core control channel, io_enable frames
	localparam logic [DATA_W-1:0] CMD_CFG      = 16'h0001;
	localparam logic [DATA_W-1:0] CMD_JOY0     = 16'h0002;
	localparam logic [DATA_W-1:0] CMD_JOY1     = 16'h0003;
	localparam logic [DATA_W-1:0] CMD_CONF_STR = 16'h0014;
	localparam logic [DATA_W-1:0] CMD_STATUS   = 16'h001E;

	// file channel, fp_enable frames
	localparam logic [DATA_W-1:0] FIO_FILE_TX     = 16'h0053;
	localparam logic [DATA_W-1:0] FIO_FILE_TX_DAT = 16'h0054;
	localparam logic [DATA_W-1:0] FIO_FILE_INDEX  = 16'h0055;

	//////////////////////////////////////////////////
	// built-in configuration string

	// must stay shorter than the saturating word index,
	// otherwise the tail bytes alias onto index 15
	localparam int CONF_LEN = 14;
	// first character sits in the top byte
	localparam logic [CONF_LEN*8-1:0] CONF_STR = "CORE;;O12,Mode";

	//////////////////////////////////////////////////
	// one data word of a frame, as seen by a decoder

	typedef struct packed {
		logic              valid;
		logic [DATA_W-1:0] cmd;
		// 1 is the first word after the command
		logic [IDX_W-1:0]  idx;
		logic [DATA_W-1:0] data;
	} hps_frame_t;

endpackage

// File: rtl/hps_frame_tracker.sv
`timescale 1ns/1ps

module hps_frame_tracker (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  logic                       strobe,
	input  logic                       enable,
	input  logic [hps_pkg::DATA_W-1:0] din,
	output hps_pkg::hps_frame_t        frame
);

	logic [hps_pkg::DATA_W-1:0] cmd_q;
	logic [hps_pkg::IDX_W-1:0]  cnt_q;
	logic [hps_pkg::IDX_W-1:0]  cnt_next;
	logic                       first_word;
	logic                       valid_q;
	logic [hps_pkg::DATA_W-1:0] out_cmd_q;
	logic [hps_pkg::IDX_W-1:0]  out_idx_q;
	logic [hps_pkg::DATA_W-1:0] out_data_q;

	// count of strobes seen so far, zero until the command arrives
	assign first_word = (cnt_q == '0);
	assign cnt_next   = (&cnt_q) ? cnt_q : cnt_q + hps_pkg::IDX_W'(1);

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cmd_q   <= '0;
			cnt_q   <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			if (!enable) begin
				cmd_q <= '0;
				cnt_q <= '0;
			end else if (strobe) begin
				cnt_q <= cnt_next;
				if (first_word) begin
					cmd_q <= din;
				end else begin
					valid_q <= 1'b1;
				end
			end
		end
	end

	// data word payload, only meaningful with valid
	always_ff @(posedge clk_sys) begin
		if (enable && strobe && !first_word) begin
			out_cmd_q  <= cmd_q;
			out_idx_q  <= cnt_q;
			out_data_q <= din;
		end
	end

	assign frame = '{valid: valid_q, cmd: out_cmd_q, idx: out_idx_q, data: out_data_q};

	// back to back frames need back to back strobes
	a_valid_needs_strobes: assert property (@(posedge clk_sys) disable iff (!rst_n)
		valid_q && $past(valid_q) |-> $past(strobe, 1) && $past(strobe, 2));

endmodule

// File: rtl/core_cmd_regs.sv
`timescale 1ns/1ps

module core_cmd_regs (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  hps_pkg::hps_frame_t        frame,
	input  logic                       enable,
	output logic [1:0]                 buttons,
	output logic                       forced_scandoubler,
	output logic                       direct_video,
	output logic [31:0]                joystick_0,
	output logic [31:0]                joystick_1,
	output logic [63:0]                status,
	output logic [hps_pkg::DATA_W-1:0] dout
);

	logic [15:0]                cfg;
	logic [7:0]                 conf_byte;
	logic [hps_pkg::DATA_W-1:0] reply;

	//////////////////////////////////////////////////
	// switches decoded from the config word

	assign buttons            = cfg[1:0];
	// bits 2, 3 and 5 belong to the system top
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	//////////////////////////////////////////////////
	// register writes

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else if (frame.valid) begin
			case (frame.cmd)
				hps_pkg::CMD_CFG: begin
					cfg <= frame.data;
				end
				hps_pkg::CMD_JOY0: begin
					if (frame.idx == 4'd1) begin
						joystick_0[15:0] <= frame.data;
					end else if (frame.idx == 4'd2) begin
						joystick_0[31:16] <= frame.data;
					end
				end
				hps_pkg::CMD_JOY1: begin
					if (frame.idx == 4'd1) begin
						joystick_1[15:0] <= frame.data;
					end else if (frame.idx == 4'd2) begin
						joystick_1[31:16] <= frame.data;
					end
				end
				hps_pkg::CMD_STATUS: begin
					// lowest slice comes first
					case (frame.idx)
						4'd1: status[15:0]  <= frame.data;
						4'd2: status[31:16] <= frame.data;
						4'd3: status[47:32] <= frame.data;
						4'd4: status[63:48] <= frame.data;
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// reply path

	// word k returns character k-1, zero past the end
	always_comb begin
		conf_byte = 8'h00;
		if (frame.idx != '0 && int'(frame.idx) <= hps_pkg::CONF_LEN) begin
			conf_byte = hps_pkg::CONF_STR[(hps_pkg::CONF_LEN - int'(frame.idx)) * 8 +: 8];
		end
	end

	always_comb begin
		reply = '0;
		if (frame.cmd == hps_pkg::CMD_CONF_STR) begin
			reply[7:0] = conf_byte;
		end
	end

	// holds the last reply until the next word or the end of frame
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			dout <= '0;
		end else if (!enable) begin
			dout <= '0;
		end else if (frame.valid) begin
			dout <= reply;
		end
	end

	// the tracker never hands over the command word itself
	a_idx_nonzero: assert property (@(posedge clk_sys) disable iff (!rst_n)
		frame.valid |-> frame.idx != '0);

endmodule

// File: rtl/file_loader.sv
`timescale 1ns/1ps

module file_loader (
	input  logic                       clk_sys,
	input  logic                       rst_n,
	input  hps_pkg::hps_frame_t        frame,
	output logic                       ioctl_download,
	output logic [15:0]                ioctl_index,
	output logic                       ioctl_wr,
	output logic [hps_pkg::ADDR_W-1:0] ioctl_addr,
	output logic [7:0]                 ioctl_dout
);

	logic [hps_pkg::ADDR_W-1:0] next_addr;
	logic                       tx_frame;
	logic                       dat_frame;
	logic                       idx_frame;

	assign tx_frame  = frame.valid && (frame.cmd == hps_pkg::FIO_FILE_TX);
	assign dat_frame = frame.valid && (frame.cmd == hps_pkg::FIO_FILE_TX_DAT);
	assign idx_frame = frame.valid && (frame.cmd == hps_pkg::FIO_FILE_INDEX);

	//////////////////////////////////////////////////
	// download state and file index

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
		end else begin
			// nonzero low byte opens, zero closes
			if (tx_frame && frame.idx == 4'd1) begin
				ioctl_download <= (frame.data[7:0] != 8'h00);
			end
			if (idx_frame) begin
				ioctl_index <= frame.data;
			end
		end
	end

	//////////////////////////////////////////////////
	// byte write pulses

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ioctl_wr <= 1'b0;
		end else begin
			ioctl_wr <= dat_frame && ioctl_download;
		end
	end

	//////////////////////////////////////////////////
	// address and data

	always_ff @(posedge clk_sys) begin
		if (tx_frame) begin
			case (frame.idx)
				4'd1: begin
					if (frame.data[7:0] != 8'h00) begin
						next_addr <= '0;
					end
				end
				// optional start address, low part then high part
				4'd2: next_addr[15:0] <= frame.data;
				4'd3: next_addr[26:16] <= frame.data[10:0];
				default: ;
			endcase
		end else if (dat_frame && ioctl_download) begin
			ioctl_addr <= next_addr;
			ioctl_dout <= frame.data[7:0];
			next_addr  <= next_addr + hps_pkg::ADDR_W'(1);
		end
	end

	// words between downloads are dropped, so no stray writes
	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ioctl_wr |-> ioctl_download);

endmodule

// File: rtl/hps_io_top.sv
`timescale 1ns/1ps

module hps_io_top (
	input  logic                       clk_sys,
	input  logic                       rst_n,

	// host bus
	input  logic                       hps_strobe,
	input  logic [hps_pkg::DATA_W-1:0] hps_din,
	input  logic                       io_enable,
	input  logic                       fp_enable,
	output logic [hps_pkg::DATA_W-1:0] hps_dout,
	output logic                       host_wait,

	// core control
	output logic [1:0]                 buttons,
	output logic                       forced_scandoubler,
	output logic                       direct_video,
	output logic [31:0]                joystick_0,
	output logic [31:0]                joystick_1,
	output logic [63:0]                status,

	// file download
	output logic                       ioctl_download,
	output logic [15:0]                ioctl_index,
	output logic                       ioctl_wr,
	output logic [hps_pkg::ADDR_W-1:0] ioctl_addr,
	output logic [7:0]                 ioctl_dout,
	input  logic                       ioctl_wait
);

	hps_pkg::hps_frame_t core_frame;
	hps_pkg::hps_frame_t file_frame;

	// core side flow control is not supported, the file side just forwards it
	assign host_wait = ioctl_wait;

	//////////////////////////////////////////////////
	// frame tracking, one per enable

	hps_frame_tracker core_trk_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.strobe  (hps_strobe),
		.enable  (io_enable),
		.din     (hps_din),
		.frame   (core_frame)
	);

	hps_frame_tracker file_trk_i (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.strobe  (hps_strobe),
		.enable  (fp_enable),
		.din     (hps_din),
		.frame   (file_frame)
	);

	//////////////////////////////////////////////////
	// command decoders

	core_cmd_regs core_regs_i (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.frame              (core_frame),
		.enable             (io_enable),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.dout               (hps_dout)
	);

	file_loader loader_i (
		.clk_sys        (clk_sys),
		.rst_n          (rst_n),
		.frame          (file_frame),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

endmodule

// File: dv/hps_host_tasks.svh
`ifndef HPS_HOST_TASKS_SVH
`define HPS_HOST_TASKS_SVH

//////////////////////////////////////////////////
// reference model state

typedef struct packed {
	logic [hps_pkg::ADDR_W-1:0] addr;
	logic [7:0]                 data;
} wr_t;

logic [15:0]                exp_cfg;
logic [31:0]                exp_joy0;
logic [31:0]                exp_joy1;
logic [63:0]                exp_status;
logic                       exp_download;
logic [hps_pkg::ADDR_W-1:0] exp_next;
logic [15:0]                exp_index;
wr_t                        exp_writes[$];
// data words of the next frame, filled by the stimulus
logic [15:0]                words[$];

// core channel rules, one data word at a time
function automatic void model_core(logic [15:0] cmd, int idx, logic [15:0] w);
	case (cmd)
		hps_pkg::CMD_CFG: begin
			exp_cfg = w;
		end
		hps_pkg::CMD_JOY0: begin
			if (idx == 1) begin
				exp_joy0[15:0] = w;
			end else if (idx == 2) begin
				exp_joy0[31:16] = w;
			end
		end
		hps_pkg::CMD_JOY1: begin
			if (idx == 1) begin
				exp_joy1[15:0] = w;
			end else if (idx == 2) begin
				exp_joy1[31:16] = w;
			end
		end
		hps_pkg::CMD_STATUS: begin
			if (idx >= 1 && idx <= 4) begin
				exp_status[(idx - 1) * 16 +: 16] = w;
			end
		end
		default: begin
		end
	endcase
endfunction

// file channel rules, writes go to the expected list
function automatic void model_file(logic [15:0] cmd, int idx, logic [15:0] w);
	wr_t e;
	if (cmd == hps_pkg::FIO_FILE_TX) begin
		if (idx == 1) begin
			exp_download = (w[7:0] != 8'h00);
			if (exp_download) begin
				exp_next = '0;
			end
		end else if (idx == 2) begin
			exp_next[15:0] = w;
		end else if (idx == 3) begin
			exp_next[26:16] = w[10:0];
		end
	end else if (cmd == hps_pkg::FIO_FILE_TX_DAT && exp_download) begin
		e.addr = exp_next;
		e.data = w[7:0];
		exp_writes.push_back(e);
		exp_next = exp_next + 27'd1;
	end else if (cmd == hps_pkg::FIO_FILE_INDEX) begin
		exp_index = w;
	end
endfunction

// character k of the config string, k counted from 1
function automatic logic [7:0] conf_char(int k);
	if (k < 1 || k > hps_pkg::CONF_LEN) begin
		return 8'h00;
	end
	return 8'(hps_pkg::CONF_STR >> (8 * (hps_pkg::CONF_LEN - k)));
endfunction

//////////////////////////////////////////////////
// host bus driving

// one word, strobe held for one cycle, then gap idle cycles
task automatic send_word(input logic [15:0] w, input int gap, input bit hold);
	@(negedge clk_sys);
	while (hold && host_wait) begin
		@(posedge clk_sys);
		hps_strobe <= 1'b0;
		@(negedge clk_sys);
	end
	@(posedge clk_sys);
	hps_strobe <= 1'b1;
	hps_din    <= w;
	repeat (gap) begin
		@(posedge clk_sys);
		hps_strobe <= 1'b0;
	end
endtask

// let the last word land, then drop the enables
task automatic close_frame();
	@(posedge clk_sys);
	hps_strobe <= 1'b0;
	repeat (2) @(posedge clk_sys);
	io_enable <= 1'b0;
	fp_enable <= 1'b0;
	repeat (2) @(posedge clk_sys);
endtask

task automatic send_frame(input bit file_ch, input logic [15:0] cmd);
	int idx;
	bit hold;
	hold = file_ch && (cmd == hps_pkg::FIO_FILE_TX_DAT);
	idx  = 0;
	@(posedge clk_sys);
	if (file_ch) begin
		fp_enable <= 1'b1;
	end else begin
		io_enable <= 1'b1;
	end
	send_word(cmd, $urandom_range(0, 2), 1'b0);
	foreach (words[i]) begin
		// word index stops at 15
		idx = (idx < 15) ? idx + 1 : 15;
		if (file_ch) begin
			model_file(cmd, idx, words[i]);
		end else begin
			model_core(cmd, idx, words[i]);
		end
		send_word(words[i], $urandom_range(0, 2), hold);
	end
	close_frame();
endtask

`endif

// File: dv/tb_hps_io.sv
`timescale 1ns/1ps

module tb_hps_io;

	localparam int N_FRAMES        = 300;
	localparam int WATCHDOG_CYCLES = N_FRAMES * 40;

	logic                       clk_sys;
	logic                       rst_n;
	logic                       hps_strobe;
	logic [15:0]                hps_din;
	logic                       io_enable;
	logic                       fp_enable;
	logic                       ioctl_wait;
	logic [15:0]                hps_dout;
	logic                       host_wait;
	logic [1:0]                 buttons;
	logic                       forced_scandoubler;
	logic                       direct_video;
	logic [31:0]                joystick_0;
	logic [31:0]                joystick_1;
	logic [63:0]                status;
	logic                       ioctl_download;
	logic [15:0]                ioctl_index;
	logic                       ioctl_wr;
	logic [hps_pkg::ADDR_W-1:0] ioctl_addr;
	logic [7:0]                 ioctl_dout;

	hps_io_top dut_i (
		.clk_sys            (clk_sys),
		.rst_n              (rst_n),
		.hps_strobe         (hps_strobe),
		.hps_din            (hps_din),
		.io_enable          (io_enable),
		.fp_enable          (fp_enable),
		.hps_dout           (hps_dout),
		.host_wait          (host_wait),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.ioctl_download     (ioctl_download),
		.ioctl_index        (ioctl_index),
		.ioctl_wr           (ioctl_wr),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout),
		.ioctl_wait         (ioctl_wait)
	);

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got == exp) else begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	task automatic report_error(input string msg);
		$display("Error: %s", msg);
		$display("** FAIL **");
		$fatal(1);
	endtask

	`include "hps_host_tasks.svh"

	// config string read, one strobe every 3 cycles
	task automatic read_conf_str(input int len);
		@(posedge clk_sys);
		io_enable <= 1'b1;
		send_word(hps_pkg::CMD_CONF_STR, 2, 1'b0);
		for (int k = 1; k <= len; k++) begin
			@(posedge clk_sys);
			hps_strobe <= 1'b1;
			hps_din    <= 16'($urandom());
			@(posedge clk_sys);
			hps_strobe <= 1'b0;
			// reply lands two edges after the strobe goes out
			@(posedge clk_sys);
			@(negedge clk_sys);
			check_val("hps_dout", 64'(hps_dout), 64'(conf_char(k)));
		end
		close_frame();
	endtask

	task automatic check_regs();
		@(negedge clk_sys);
		check_val("buttons", 64'(buttons), 64'(exp_cfg[1:0]));
		check_val("forced_scandoubler", 64'(forced_scandoubler), 64'(exp_cfg[4]));
		check_val("direct_video", 64'(direct_video), 64'(exp_cfg[10]));
		check_val("joystick_0", 64'(joystick_0), 64'(exp_joy0));
		check_val("joystick_1", 64'(joystick_1), 64'(exp_joy1));
		check_val("status", status, exp_status);
		check_val("ioctl_download", 64'(ioctl_download), 64'(exp_download));
		check_val("ioctl_index", 64'(ioctl_index), 64'(exp_index));
		// enable is low again here
		check_val("hps_dout", 64'(hps_dout), 64'h0);
	endtask

	function automatic logic [15:0] core_cmd(int kind);
		case (kind)
			0: return hps_pkg::CMD_CFG;
			1: return hps_pkg::CMD_JOY0;
			2: return hps_pkg::CMD_JOY1;
			default: return hps_pkg::CMD_STATUS;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// clock, wait generator, monitors

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	initial begin
		forever begin
			@(posedge clk_sys);
			if (rst_n) begin
				ioctl_wait <= ($urandom_range(0, 3) == 0);
			end
		end
	end

	// write pulses against the expected list, wait passthrough
	initial begin
		wr_t e;
		forever begin
			@(negedge clk_sys);
			if (rst_n) begin
				check_val("host_wait", 64'(host_wait), 64'(ioctl_wait));
				if (ioctl_wr) begin
					assert (exp_writes.size() != 0) begin
						e = exp_writes.pop_front();
						check_val("ioctl_addr", 64'(ioctl_addr), 64'(e.addr));
						check_val("ioctl_dout", 64'(ioctl_dout), 64'(e.data));
					end else begin
						report_error("write pulse with no expected write");
					end
				end
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("** FAIL **");
		$fatal(1);
	end

	//////////////////////////////////////////////////
	// stimulus

	initial begin
		int kind;
		int len;
		rst_n        = 1'b0;
		hps_strobe   = 1'b0;
		hps_din      = '0;
		io_enable    = 1'b0;
		fp_enable    = 1'b0;
		ioctl_wait   = 1'b0;
		exp_cfg      = '0;
		exp_joy0     = '0;
		exp_joy1     = '0;
		exp_status   = '0;
		exp_download = 1'b0;
		exp_next     = '0;
		exp_index    = '0;
		void'($urandom(32'hb0b3));
		repeat (10) @(posedge clk_sys);
		rst_n <= 1'b1;

		@(negedge clk_sys);
		check_val("core frame valid", 64'(dut_i.core_frame.valid), 64'h0);
		check_val("file frame valid", 64'(dut_i.file_frame.valid), 64'h0);
		check_val("ioctl_wr", 64'(ioctl_wr), 64'h0);
		check_regs();

		for (int n = 0; n < N_FRAMES; n++) begin
			kind = $urandom_range(0, 9);
			words.delete();
			case (kind)
				0, 1, 2, 3: begin
					// partial frames included
					len = $urandom_range(0, 6);
					repeat (len) words.push_back(16'($urandom()));
					send_frame(1'b0, core_cmd(kind));
				end
				4: begin
					read_conf_str($urandom_range(1, hps_pkg::CONF_LEN + 3));
				end
				5: begin
					words.push_back(16'($urandom()));
					send_frame(1'b1, hps_pkg::FIO_FILE_INDEX);
				end
				6: begin
					// start, then optional address words
					words.push_back({8'($urandom()), 8'($urandom_range(1, 255))});
					len = $urandom_range(0, 2);
					repeat (len) words.push_back(16'($urandom()));
					send_frame(1'b1, hps_pkg::FIO_FILE_TX);
				end
				7: begin
					words.push_back({8'($urandom()), 8'h00});
					send_frame(1'b1, hps_pkg::FIO_FILE_TX);
				end
				default: begin
					len = $urandom_range(1, 12);
					repeat (len) words.push_back(16'($urandom()));
					send_frame(1'b1, hps_pkg::FIO_FILE_TX_DAT);
				end
			endcase
			check_regs();
		end

		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		assert (exp_writes.size() == 0) begin
			$display("** PASS **");
			$finish;
		end else begin
			report_error("expected writes never appeared on the ioctl bus");
		end
	end

endmodule

// File: vlog.f
+incdir+dv
rtl/hps_pkg.sv
rtl/hps_frame_tracker.sv
rtl/core_cmd_regs.sv
rtl/file_loader.sv
rtl/hps_io_top.sv
dv/tb_hps_io.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_hps_io -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '^\*\* PASS \*\*$' "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
